//--- common/calc_pkg.sv
package calc_pkg;

    // Operation picked by the operator key
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } calc_op_t;

    // Unsigned operand or result, wraps modulo 2^16
    typedef logic [15:0] calc_word_t;

    // Controller states
    typedef enum logic [2:0] {
        get_first_num  = 3'd0,  // Building operand1
        get_second_num = 3'd1,  // Building operand2
        send_to_alu    = 3'd2,  // Start pulse issued on exit
        wait_alu       = 3'd3,  // Waiting on ALU finish
        show_result    = 3'd4   // Display updated, log written
    } calc_state_t;

    // Request to the ALU, valid while start is high
    typedef struct packed {
        calc_op_t   op;
        calc_word_t in1;
        calc_word_t in2;
    } alu_req_t;

    // ALU answer, valid while finish is high
    typedef struct packed {
        calc_word_t result;
    } alu_rsp_t;

    // One multiplier bit per step
    localparam int MUL_STEPS = 16;

endpackage

//--- hdl/calc_alu.sv
`timescale 1ns/10ps

// Add and subtract answer one cycle after start is sampled.
// Multiply walks the multiplier from the LSB, adding a shifted copy of
// the multiplicand for every set bit, and keeps only the low 16 bits.
module calc_alu import calc_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  alu_req_t req,
    output logic     finish,
    output alu_rsp_t rsp
);

    localparam int                CNT_W     = $clog2(MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(MUL_STEPS - 1);

    calc_word_t        multiplicand;  // Shifts left each step
    calc_word_t        multiplier;    // Shifts right each step
    calc_word_t        acc;           // Running sum, then the result
    calc_word_t        partial;       // Partial product of this step
    logic [CNT_W-1:0]  step_cnt;
    logic              mul_busy;
    logic              accept;

    assign accept     = start && !mul_busy;
    assign partial    = multiplier[0] ? multiplicand : '0;
    assign rsp.result = acc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_busy <= 1'b0;
            step_cnt <= '0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;  // Pulse by default
            if (accept) begin
                if (req.op == op_mul) begin
                    mul_busy <= 1'b1;
                    step_cnt <= '0;
                end else begin
                    finish <= 1'b1;  // Add and subtract are single cycle
                end
            end else if (mul_busy) begin
                step_cnt <= step_cnt + CNT_W'(1);
                if (step_cnt == LAST_STEP) begin
                    mul_busy <= 1'b0;
                    finish   <= 1'b1;  // Last partial product lands now
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            multiplicand <= req.in1;
            multiplier   <= req.in2;
            case (req.op)
                op_sub:  acc <= req.in1 - req.in2;  // Wraps below zero
                op_mul:  acc <= '0;
                default: acc <= req.in1 + req.in2;
            endcase
        end else if (mul_busy) begin
            acc          <= acc + partial;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    // The controller must not issue a new request mid-multiply
    assert property (@(posedge clk) disable iff (reset) mul_busy |-> !start)
        else $error("ALU start seen while a multiply is running");

endmodule

//--- hdl/result_log.sv
`timescale 1ns/10ps

// Small store of past results. The controller writes through we/waddr,
// while the outside reads through addr/oe with one cycle of latency.
module result_log import calc_pkg::*; #(
    parameter int LOG_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         we,
    input  logic [$clog2(LOG_DEPTH)-1:0] waddr,
    input  calc_word_t                   wdata,
    input  logic [$clog2(LOG_DEPTH)-1:0] addr,
    input  logic                         oe,
    output calc_word_t                   data
);

    calc_word_t entries [LOG_DEPTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < LOG_DEPTH; i++) begin
                entries[i] <= '0;  // Log starts empty
            end
            data <= '0;
        end else begin
            if (we) begin
                entries[waddr] <= wdata;
            end
            if (oe) begin
                data <= entries[addr];  // Holds when oe is low
            end
        end
    end

endmodule

//--- controller/calc_controller.sv
`timescale 1ns/10ps

// Keypad entry and sequencing for one calculation.
// Digits build operand1 until an operator arrives, then operand2 until
// equal. The operands go to the ALU with a single start pulse, and the
// answer is shown, flagged by complete and appended to the result log.
module calc_controller import calc_pkg::*; #(
    parameter int LOG_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         key_valid,
    input  logic [3:0]                   key_digit,
    input  logic                         op_valid,
    input  calc_op_t                     op_sel,
    input  logic                         equal_valid,
    input  logic                         alu_finish,
    input  alu_rsp_t                     alu_rsp,
    output logic                         alu_start,
    output alu_req_t                     alu_req,
    output calc_word_t                   display_output,
    output logic                         complete,
    output logic                         busy,
    output logic                         log_we,
    output logic [$clog2(LOG_DEPTH)-1:0] log_waddr,
    output calc_word_t                   log_wdata
);

    localparam int ADDR_W = $clog2(LOG_DEPTH);

    calc_state_t       state;
    calc_state_t       next_state;
    calc_word_t        operand1;
    calc_word_t        operand2;
    calc_op_t          op_q;       // Operation latched by the operator key
    logic [ADDR_W-1:0] wr_ptr;     // Next log slot
    logic              digit_ok;

    // value * 10 + digit, truncated to 16 bits
    function automatic calc_word_t append_digit(calc_word_t value, logic [3:0] digit);
        calc_word_t times_ten;
        times_ten = (value << 3) + (value << 1);
        return times_ten + calc_word_t'(digit);
    endfunction

    assign digit_ok = key_valid && (key_digit <= 4'd9);  // Non-decimal keys dropped

    always_comb begin
        next_state = state;
        case (state)
            get_first_num: begin
                if (op_valid) begin
                    next_state = get_second_num;
                end
            end
            get_second_num: begin
                if (equal_valid) begin
                    next_state = send_to_alu;
                end
            end
            send_to_alu: begin
                next_state = wait_alu;
            end
            wait_alu: begin
                if (alu_finish) begin
                    next_state = show_result;
                end
            end
            show_result: begin
                next_state = get_first_num;
            end
            default: begin
                next_state = get_first_num;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= get_first_num;
            alu_start      <= 1'b0;
            display_output <= '0;
            wr_ptr         <= '0;
        end else begin
            state     <= next_state;
            alu_start <= (state == send_to_alu);  // Single pulse on leaving send_to_alu
            if (state == wait_alu && alu_finish) begin
                display_output <= alu_rsp.result;
            end
            if (state == show_result) begin
                wr_ptr <= wr_ptr + ADDR_W'(1);  // Wraps at LOG_DEPTH
            end
        end
    end

    // Operand entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operand1 <= '0;
            operand2 <= '0;
            op_q     <= op_add;
        end else begin
            case (state)
                get_first_num: begin
                    if (digit_ok) begin
                        operand1 <= append_digit(operand1, key_digit);
                    end
                    if (op_valid) begin
                        op_q     <= op_sel;
                        operand2 <= '0;  // Fresh second operand
                    end
                end
                get_second_num: begin
                    if (digit_ok) begin
                        operand2 <= append_digit(operand2, key_digit);
                    end
                end
                show_result: begin
                    operand1 <= '0;  // Ready for the next entry
                    operand2 <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    assign alu_req = '{op: op_q, in1: operand1, in2: operand2};

    assign complete  = (state == show_result);
    assign log_we    = (state == show_result);
    assign log_waddr = wr_ptr;
    assign log_wdata = display_output;  // Already holds the new result
    assign busy      = (state == send_to_alu) || (state == wait_alu) ||
                       (state == show_result);

    assert property (@(posedge clk) disable iff (reset) alu_start |=> !alu_start)
        else $error("alu_start held for more than one cycle");

    // A finish outside wait_alu means the ALU and controller lost step
    assert property (@(posedge clk) disable iff (reset) alu_finish |-> state == wait_alu)
        else $error("ALU finish arrived outside wait_alu");

endmodule

//--- hdl/calc_top.sv
`timescale 1ns/10ps

// Calculator core, with the controller beside the ALU and the result log
module calc_top import calc_pkg::*; #(
    parameter int LOG_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         key_valid,
    input  logic [3:0]                   key_digit,
    input  logic                         op_valid,
    input  calc_op_t                     op_sel,
    input  logic                         equal_valid,
    input  logic [$clog2(LOG_DEPTH)-1:0] log_addr,
    input  logic                         log_oe,
    output calc_word_t                   display_output,
    output logic                         complete,
    output logic                         busy,
    output calc_word_t                   log_data
);

    logic                         alu_start;
    alu_req_t                     alu_req;
    logic                         alu_finish;
    alu_rsp_t                     alu_rsp;
    logic                         log_we;
    logic [$clog2(LOG_DEPTH)-1:0] log_waddr;
    calc_word_t                   log_wdata;

    calc_controller #(
        .LOG_DEPTH(LOG_DEPTH)
    ) u_controller (
        .clk           (clk),
        .reset         (reset),
        .key_valid     (key_valid),
        .key_digit     (key_digit),
        .op_valid      (op_valid),
        .op_sel        (op_sel),
        .equal_valid   (equal_valid),
        .alu_finish    (alu_finish),
        .alu_rsp       (alu_rsp),
        .alu_start     (alu_start),
        .alu_req       (alu_req),
        .display_output(display_output),
        .complete      (complete),
        .busy          (busy),
        .log_we        (log_we),
        .log_waddr     (log_waddr),
        .log_wdata     (log_wdata)
    );

    calc_alu u_alu (
        .clk   (clk),
        .reset (reset),
        .start (alu_start),
        .req   (alu_req),
        .finish(alu_finish),
        .rsp   (alu_rsp)
    );

    result_log #(
        .LOG_DEPTH(LOG_DEPTH)
    ) u_log (
        .clk  (clk),
        .reset(reset),
        .we   (log_we),
        .waddr(log_waddr),
        .wdata(log_wdata),
        .addr (log_addr),
        .oe   (log_oe),
        .data (log_data)
    );

endmodule

//--- dv/calc_tb.sv
`timescale 1ns/10ps

module calc_tb import calc_pkg::*; ();

    localparam int LOG_DEPTH      = 8;
    localparam int ADDR_W         = $clog2(LOG_DEPTH);
    localparam int ADD_SUB_CYCLES = 4;     // Equal drive to complete seen, fixed ALU latency
    localparam int MAX_WAIT       = 40;    // Multiply needs about twenty
    localparam int CYCLE_LIMIT    = 4000;  // About 25 calculations of 60 cycles, with margin

    logic              clk;
    logic              reset;
    logic              key_valid;
    logic [3:0]        key_digit;
    logic              op_valid;
    calc_op_t          op_sel;
    logic              equal_valid;
    logic [ADDR_W-1:0] log_addr;
    logic              log_oe;
    calc_word_t        display_output;
    logic              complete;
    logic              busy;
    calc_word_t        log_data;

    int          cycle_count = 0;
    int          error_count = 0;
    calc_word_t  expected_q[$];  // Results awaiting their complete pulse
    calc_word_t  results[$];     // Every result, oldest first

    calc_top #(
        .LOG_DEPTH(LOG_DEPTH)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .key_valid     (key_valid),
        .key_digit     (key_digit),
        .op_valid      (op_valid),
        .op_sel        (op_sel),
        .equal_valid   (equal_valid),
        .log_addr      (log_addr),
        .log_oe        (log_oe),
        .display_output(display_output),
        .complete      (complete),
        .busy          (busy),
        .log_data      (log_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(string msg);
        error_count++;
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(string what, calc_word_t got, calc_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;  // Drive and sample just after the edge
    endtask

    // Decimal string to operand, wrapping modulo 2^16; non-digits are skipped
    function automatic calc_word_t to_word(string s);
        calc_word_t v;
        logic [7:0] ch;
        v = '0;
        for (int i = 0; i < s.len(); i++) begin
            ch = s[i];
            if (ch >= 8'd48 && ch <= 8'd57) begin
                v = calc_word_t'(v * 16'd10 + calc_word_t'(ch - 8'd48));
            end
        end
        return v;
    endfunction

    function automatic calc_word_t calc_ref(calc_op_t op, string a, string b);
        calc_word_t  in1;
        calc_word_t  in2;
        logic [31:0] product;
        in1 = to_word(a);
        in2 = to_word(b);
        product = 32'(in1) * 32'(in2);
        case (op)
            op_add:  return in1 + in2;
            op_sub:  return in1 - in2;
            default: return product[15:0];
        endcase
    endfunction

    function automatic string random_number();
        string s;
        int    len;
        s = "";
        len = int'($urandom_range(6, 1));
        for (int i = 0; i < len; i++) begin
            s = $sformatf("%s%0d", s, $urandom_range(9, 0));
        end
        return s;
    endfunction

    task automatic send_key(logic [3:0] digit);
        key_valid = 1'b1;
        key_digit = digit;
        tick();
        key_valid = 1'b0;
    endtask

    // Letters in the string become keys 10 to 15
    task automatic enter_number(string s);
        logic [7:0] ch;
        for (int i = 0; i < s.len(); i++) begin
            ch = s[i];
            if (ch >= 8'd48 && ch <= 8'd57) begin
                send_key(4'(ch - 8'd48));
            end else begin
                send_key(4'(10 + ch % 6));
            end
        end
    endtask

    task automatic run_calc(calc_op_t op, string a, string b, bit noise);
        calc_word_t exp;
        int         wait_cycles;
        exp = calc_ref(op, a, b);
        expected_q.push_back(exp);
        results.push_back(exp);
        enter_number(a);
        op_valid = 1'b1;
        op_sel   = op;
        tick();
        op_valid = 1'b0;
        enter_number(b);
        equal_valid = 1'b1;
        tick();
        equal_valid = 1'b0;
        wait_cycles = 1;
        while (!complete) begin
            check_bit("busy during calculation", busy, 1'b1);
            if (wait_cycles >= MAX_WAIT) begin
                report_failure("complete never pulsed after equal");
            end
            if (noise) begin  // Every strobe while busy
                key_valid   = 1'b1;
                key_digit   = 4'($urandom_range(9, 0));
                op_valid    = 1'b1;
                op_sel      = op_add;
                equal_valid = 1'b1;
            end
            tick();
            key_valid   = 1'b0;
            op_valid    = 1'b0;
            equal_valid = 1'b0;
            wait_cycles++;
        end
        check_bit("busy with complete", busy, 1'b1);
        if (op != op_mul && wait_cycles != ADD_SUB_CYCLES) begin
            report_failure($sformatf("add or subtract took %0d cycles, expected %0d",
                                     wait_cycles, ADD_SUB_CYCLES));
        end
        tick();
        check_bit("complete after its pulse", complete, 1'b0);
        check_bit("busy after calculation", busy, 1'b0);
    endtask

    // Equal while entering the first operand must not start anything
    task automatic stray_equal();
        equal_valid = 1'b1;
        tick();
        equal_valid = 1'b0;
        repeat (3) begin
            check_bit("busy after stray equal", busy, 1'b0);
            tick();
        end
    endtask

    task automatic check_log();
        int n;
        int wp;
        n  = results.size();
        wp = n % LOG_DEPTH;  // Oldest slot once the log has wrapped
        for (int i = 0; i < LOG_DEPTH; i++) begin
            log_addr = ADDR_W'((wp + i) % LOG_DEPTH);
            log_oe   = 1'b1;
            tick();
            log_oe = 1'b0;
            check_word($sformatf("log slot %0d", (wp + i) % LOG_DEPTH), log_data,
                       results[n - LOG_DEPTH + i]);
        end
        log_addr = ADDR_W'(wp);
        tick();
        check_word("log_data with oe low", log_data, results[n - 1]);
    endtask

    // Display checked against the oldest pending result
    always @(negedge clk) begin
        if (!reset && complete) begin
            if (expected_q.size() == 0) begin
                report_failure("complete pulsed with no calculation pending");
            end else begin
                check_word("display_output", display_output, expected_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Simulation timed out after %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        void'($urandom(60));
        reset       = 1'b1;
        key_valid   = 1'b0;
        key_digit   = 4'd0;
        op_valid    = 1'b0;
        op_sel      = op_add;
        equal_valid = 1'b0;
        log_addr    = '0;
        log_oe      = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        check_bit("complete after reset", complete, 1'b0);
        check_bit("busy after reset", busy, 1'b0);
        check_word("display after reset", display_output, 16'd0);
        log_oe = 1'b1;
        tick();
        log_oe = 1'b0;
        check_word("log slot 0 after reset", log_data, 16'd0);

        run_calc(op_add, "123", "456", 1'b0);
        run_calc(op_sub, "1000", "250", 1'b0);
        run_calc(op_sub, "5", "7", 1'b0);  // Wraps below zero
        run_calc(op_mul, "300", "250", 1'b0);
        run_calc(op_mul, "65535", "65535", 1'b0);

        run_calc(op_add, "70000", "1", 1'b0);  // Entry wraps at 2^16
        run_calc(op_mul, "123456789", "3", 1'b0);
        run_calc(op_sub, "1x2y3", "9z", 1'b0);  // Keys above 9 dropped

        stray_equal();
        run_calc(op_mul, "123", "45", 1'b1);
        run_calc(op_add, "9", "9", 1'b1);
        run_calc(op_sub, "42", "17", 1'b0);

        for (int k = 0; k < 12; k++) begin
            run_calc(calc_op_t'(2'($urandom_range(2, 0))), random_number(), random_number(),
                     (k % 3) == 0);
        end
        check_log();

        if (expected_q.size() != 0) begin
            report_failure("a calculation ended without a complete pulse");
        end
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- calc.f
common/calc_pkg.sv
hdl/calc_alu.sv
hdl/result_log.sv
controller/calc_controller.sv
hdl/calc_top.sv
dv/calc_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module calc_tb -f calc.f -o calc_sim

sim_out=$(./obj_dir/calc_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'; then
    exit 0
fi
exit 1
